//--- fmlbrg_pkg.sv
`default_nettype none

package fmlbrg_pkg;

  // the FML side addresses bytes, and one word holds two of them.
  localparam int FML_DEPTH = 12;            // 4 KiB of burst memory behind the bridge.
  localparam int CACHE_DEPTH = 9;           // 512 bytes of cache, which is 32 lines.

  // one line is one burst of 8 words, so 16 bytes.
  localparam int OFFSET_W = 3;              // word offset inside a line.
  localparam int INDEX_W = CACHE_DEPTH - 4; // selects one of the cache lines.
  localparam int TAG_W = FML_DEPTH - CACHE_DEPTH; // upper address bits kept per line.

  // tag entry layout is valid, dirty, then the tag itself in the low bits.
  localparam int TAGMEM_W = TAG_W + 2;

  // the data memory is addressed by index and word offset together.
  localparam int DATAMEM_AW = INDEX_W + OFFSET_W;

  localparam int BURST_LEN = 8;             // beats in every FML burst.
  localparam int FML_ACK_LATENCY = 3;       // cycles from a new strobe to the ack.

  // power-up pattern of the memory model.
  // word w holds w xor this value until it is first written.
  localparam logic [15:0] FML_INIT_XOR = 16'hA5C3;

endpackage

`default_nettype wire

//--- fmlbrg_tagmem.sv
`timescale 1ns/1ns
`default_nettype none

module fmlbrg_tagmem (
  input  logic                               sys_clk,
  input  logic                               sys_rst,
  input  logic [fmlbrg_pkg::INDEX_W-1:0]     tagmem_a_i,
  input  logic                               tagmem_we_i,
  input  logic [fmlbrg_pkg::TAGMEM_W-1:0]    tagmem_di_i,
  output logic [fmlbrg_pkg::TAGMEM_W-1:0]    tagmem_do_o,
  output logic                               init_done_o
);
  import fmlbrg_pkg::*;

  logic [TAGMEM_W-1:0] tags [0:(1 << INDEX_W)-1]; // one entry per cache line.
  logic [INDEX_W-1:0]  sweep_cnt;                  // entry cleared in this cycle.

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      sweep_cnt <= '0;
      init_done_o <= 1'b0;
    end else if (!init_done_o) begin
      sweep_cnt <= sweep_cnt + 1'b1;             // one entry per cycle.
      if (sweep_cnt == '1) init_done_o <= 1'b1;  // the last entry is cleared now.
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!init_done_o) begin
      tags[sweep_cnt] <= '0;                     // valid and dirty drop with the tag.
      tagmem_do_o <= '0;
    end else if (tagmem_we_i) begin
      tags[tagmem_a_i] <= tagmem_di_i;
      tagmem_do_o <= tagmem_di_i;                // the new entry shows at once.
    end else begin
      tagmem_do_o <= tags[tagmem_a_i];           // plain read of the indexed line.
    end
  end

endmodule

`default_nettype wire

//--- fmlbrg_datamem.sv
`timescale 1ns/1ns
`default_nettype none

module fmlbrg_datamem (
  input  logic                                sys_clk,
  input  logic [fmlbrg_pkg::DATAMEM_AW-1:0]   datamem_a_i,
  input  logic [1:0]                          datamem_we_i,
  input  logic [15:0]                         datamem_di_i,
  output logic [15:0]                         datamem_do_o
);
  import fmlbrg_pkg::*;

  // each byte lane is its own RAM with its own write enable.
  // a lane being written returns the new byte on the same edge.
  for (genvar l = 0; l < 2; l++) begin : g_lane
    logic [7:0] mem [0:(1 << DATAMEM_AW)-1]; // one byte of every cached word.
    logic [7:0] rd_q;                         // registered read port of this lane.

    always_ff @(posedge sys_clk) begin
      if (datamem_we_i[l]) begin
        mem[datamem_a_i] <= datamem_di_i[8*l +: 8];
        rd_q <= datamem_di_i[8*l +: 8];       // write-first bypass.
      end else begin
        rd_q <= mem[datamem_a_i];
      end
    end

    assign datamem_do_o[8*l +: 8] = rd_q;     // lanes rejoin into one word.
  end

endmodule

`default_nettype wire

//--- fmlbrg.sv
`timescale 1ns/1ns
`default_nettype none

module fmlbrg (
  input  logic                               sys_clk,
  input  logic                               sys_rst,
  input  logic [fmlbrg_pkg::FML_DEPTH-1:1]   wb_adr_i,
  input  logic [15:0]                        wb_dat_i,
  input  logic [1:0]                         wb_sel_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_tga_i,
  input  logic                               wb_we_i,
  output logic [15:0]                        wb_dat_o,
  output logic                               wb_ack_o,
  output logic [fmlbrg_pkg::INDEX_W-1:0]     tagmem_a_o,
  output logic                               tagmem_we_o,
  output logic [fmlbrg_pkg::TAGMEM_W-1:0]    tagmem_di_o,
  input  logic [fmlbrg_pkg::TAGMEM_W-1:0]    tagmem_do_i,
  input  logic                               tag_init_done_i,
  output logic [fmlbrg_pkg::DATAMEM_AW-1:0]  datamem_a_o,
  output logic [1:0]                         datamem_we_o,
  output logic [15:0]                        datamem_di_o,
  input  logic [15:0]                        datamem_do_i,
  output logic [fmlbrg_pkg::FML_DEPTH-1:0]   fml_adr_o,
  output logic                               fml_stb_o,
  output logic                               fml_we_o,
  output logic [1:0]                         fml_sel_o,
  output logic [15:0]                        fml_do_o,
  input  logic                               fml_ack_i,
  input  logic [15:0]                        fml_di_i
);
  import fmlbrg_pkg::*;

  // beat states are numbered in sequence so a step is a plus one.
  typedef enum logic [4:0] {
    IDLE, TEST_HIT, WRITE_HIT,
    EVICT, EVICT2, EVICT3, EVICT4, EVICT5, EVICT6, EVICT7, EVICT8,
    REFILL, REFILL_WAIT,
    REFILL1, REFILL2, REFILL3, REFILL4, REFILL5, REFILL6, REFILL7, REFILL8,
    TEST_INVALIDATE, INVALIDATE
  } state_t;

  state_t              state, next_state;
  logic [OFFSET_W-1:0] offset;          // word inside the line.
  logic [INDEX_W-1:0]  index;           // line selected by the request.
  logic [TAG_W-1:0]    tag;             // tag of the request.
  logic [INDEX_W-1:0]  index_r;         // index kept while the master moves on.
  logic [TAG_W-1:0]    tag_r;           // request tag lined up with the tag read.
  logic                do_valid, do_dirty;
  logic [TAG_W-1:0]    do_tag;          // tag stored for the indexed line.
  logic                cache_hit;
  logic [OFFSET_W-1:0] bcounter, bcounter_next;
  logic                bcounter_load, bcounter_en;
  logic                index_load;
  logic                di_valid, di_dirty;
  logic                datamem_we_wb, datamem_we_fml;
  logic                ack_next;

  assign offset = wb_adr_i[OFFSET_W:1];
  assign index = wb_adr_i[CACHE_DEPTH-1:OFFSET_W+1];
  assign tag = wb_adr_i[FML_DEPTH-1:CACHE_DEPTH];

  assign do_valid = tagmem_do_i[TAGMEM_W-1];
  assign do_dirty = tagmem_do_i[TAGMEM_W-2];
  assign do_tag = tagmem_do_i[TAG_W-1:0];
  assign cache_hit = do_valid & (do_tag == tag_r); // compared one cycle after the read.

  assign tagmem_a_o = index;                       // the master holds the address.
  assign tagmem_di_o = {di_valid, di_dirty, tag};

  always_ff @(posedge sys_clk) begin
    tag_r <= tag;
    if (index_load) index_r <= index;
    fml_adr_o <= {do_tag, index, offset, 1'b0}; // stored tag picks evict or refill line.
  end

  always_comb begin
    if (bcounter_load) bcounter_next = offset;   // critical word goes first.
    else if (bcounter_en) bcounter_next = bcounter + OFFSET_W'(1); // wraps in the line.
    else bcounter_next = bcounter;
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) bcounter <= '0;
    else bcounter <= bcounter_next;
  end

  assign datamem_a_o = {(index_load ? index : index_r), bcounter_next};
  assign datamem_we_o = {2{datamem_we_fml}} | ({2{datamem_we_wb}} & wb_sel_i);

  always_comb begin
    datamem_di_o = fml_di_i;                     // refill data by default.
    if (datamem_we_wb) begin
      if (wb_sel_i[0]) datamem_di_o[7:0] = wb_dat_i[7:0];   // master wins on its bytes.
      if (wb_sel_i[1]) datamem_di_o[15:8] = wb_dat_i[15:8];
    end
  end

  assign wb_dat_o = datamem_do_i;
  assign fml_do_o = datamem_do_i;                // eviction reads the line out here.
  assign fml_sel_o = 2'b11;                      // bursts always move whole words.

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= IDLE;
      wb_ack_o <= 1'b0;
    end else begin
      state <= next_state;
      wb_ack_o <= ack_next;                      // ack is registered for a clean edge.
    end
  end

  always_comb begin
    next_state = state;
    tagmem_we_o = 1'b0;
    di_valid = 1'b0;
    di_dirty = 1'b0;
    bcounter_load = 1'b0;
    bcounter_en = 1'b0;
    index_load = 1'b1;
    datamem_we_wb = 1'b0;
    datamem_we_fml = 1'b0;
    ack_next = 1'b0;
    fml_stb_o = 1'b0;
    fml_we_o = 1'b0;
    case (state)
      IDLE: begin
        bcounter_load = 1'b1;
        // a request still showing its ack is the one just finished.
        if (tag_init_done_i && wb_cyc_i && wb_stb_i && !wb_ack_o) begin
          next_state = wb_tga_i ? TEST_INVALIDATE : TEST_HIT;
        end
      end
      TEST_HIT: begin
        if (cache_hit) begin
          if (wb_we_i) begin
            next_state = WRITE_HIT;
          end else begin
            ack_next = 1'b1;                     // the data memory already holds the word.
            next_state = IDLE;
          end
        end else begin
          next_state = do_dirty ? EVICT : REFILL;
        end
      end
      WRITE_HIT: begin
        di_valid = 1'b1;
        di_dirty = 1'b1;
        tagmem_we_o = 1'b1;
        datamem_we_wb = 1'b1;
        ack_next = 1'b1;
        next_state = IDLE;
      end
      EVICT: begin
        fml_stb_o = 1'b1;                        // address holds the victim tag here.
        fml_we_o = 1'b1;
        if (fml_ack_i) begin
          bcounter_en = 1'b1;
          next_state = EVICT2;
        end
      end
      EVICT2, EVICT3, EVICT4, EVICT5, EVICT6, EVICT7: begin
        bcounter_en = 1'b1;
        next_state = state_t'(state + 5'd1);
      end
      EVICT8: begin
        bcounter_en = 1'b1;                      // counter wraps back to the offset.
        next_state = wb_tga_i ? INVALIDATE : REFILL;
      end
      REFILL: begin
        di_valid = 1'b1;
        di_dirty = wb_we_i;                      // a write miss leaves the line dirty.
        tagmem_we_o = 1'b1;
        next_state = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        next_state = REFILL1;                    // lets the FML address pick up the new tag.
      end
      REFILL1: begin
        bcounter_load = 1'b1;
        fml_stb_o = 1'b1;
        datamem_we_fml = 1'b1;
        datamem_we_wb = wb_we_i;
        if (fml_ack_i) begin
          ack_next = 1'b1;                       // critical word lands on this edge.
          next_state = REFILL2;
        end
      end
      REFILL2, REFILL3, REFILL4, REFILL5, REFILL6, REFILL7: begin
        index_load = 1'b0;                       // master may already show a new address.
        datamem_we_fml = 1'b1;
        bcounter_en = 1'b1;
        next_state = state_t'(state + 5'd1);
      end
      REFILL8: begin
        index_load = 1'b0;
        datamem_we_fml = 1'b1;
        bcounter_en = 1'b1;
        next_state = IDLE;
      end
      TEST_INVALIDATE: begin
        next_state = do_dirty ? EVICT : INVALIDATE;
      end
      INVALIDATE: begin
        tagmem_we_o = 1'b1;                      // valid and dirty are written low.
        ack_next = 1'b1;
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- fml_burst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module fml_burst_mem (
  input  logic                               sys_clk,
  input  logic                               sys_rst,
  input  logic [fmlbrg_pkg::FML_DEPTH-1:0]   fml_adr_i,
  input  logic                               fml_stb_i,
  input  logic                               fml_we_i,
  input  logic [1:0]                         fml_sel_i,
  input  logic [15:0]                        fml_do_i,
  output logic                               fml_ack_o,
  output logic [15:0]                        fml_di_o
);
  import fmlbrg_pkg::*;

  logic [15:0]                   mem [0:(1 << (FML_DEPTH-1))-1]; // word array of the memory.
  logic                          busy;       // a burst has been accepted.
  logic                          bursting;   // beats 1 to 7 are running.
  logic [$clog2(FML_ACK_LATENCY+1)-1:0] lat_cnt; // cycles since the strobe was taken.
  logic [OFFSET_W-1:0]           beat;       // beat number after the ack.
  logic [FML_DEPTH-OFFSET_W-2:0] line_q;     // word-line address of the burst.
  logic [OFFSET_W-1:0]           offs_q;     // first word of the burst.
  logic                          we_q;       // burst direction.
  logic [OFFSET_W-1:0]           cur_beat;
  logic [OFFSET_W-1:0]           word_off;
  logic [FML_DEPTH-2:0]          word_a;     // word touched in this cycle.
  logic                          beat_act;   // a data beat is on the bus.

  initial begin
    for (int w = 0; w < (1 << (FML_DEPTH-1)); w++) begin
      mem[w] = w[15:0] ^ FML_INIT_XOR;        // known pattern at power-up.
    end
  end

  assign fml_ack_o = busy && !bursting && (lat_cnt == $bits(lat_cnt)'(FML_ACK_LATENCY - 1));
  assign cur_beat = bursting ? beat : '0;     // the ack cycle is beat 0.
  assign word_off = offs_q + cur_beat;        // wraps inside the line.
  assign word_a = {line_q, word_off};
  assign beat_act = fml_ack_o || bursting;
  assign fml_di_o = mem[word_a];

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      busy <= 1'b0;
      bursting <= 1'b0;
      lat_cnt <= '0;
      beat <= '0;
    end else if (!busy) begin
      if (fml_stb_i) begin
        busy <= 1'b1;                         // strobe taken, start the latency count.
        lat_cnt <= '0;
      end
    end else if (!bursting) begin
      if (fml_ack_o) begin
        bursting <= 1'b1;
        beat <= OFFSET_W'(1);
      end else begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end else begin
      beat <= beat + OFFSET_W'(1);
      if (beat == OFFSET_W'(BURST_LEN - 1)) begin
        busy <= 1'b0;                         // last beat, ready for the next strobe.
        bursting <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!busy && fml_stb_i) begin
      line_q <= fml_adr_i[FML_DEPTH-1:OFFSET_W+1];
      offs_q <= fml_adr_i[OFFSET_W:1];        // byte bit 0 carries no word information.
      we_q <= fml_we_i;
    end
  end

  always @(posedge sys_clk) begin
    if (beat_act && we_q) begin
      if (fml_sel_i[0]) mem[word_a][7:0] <= fml_do_i[7:0];
      if (fml_sel_i[1]) mem[word_a][15:8] <= fml_do_i[15:8];
    end
  end

endmodule

`default_nettype wire

//--- fmlbrg_top.sv
`timescale 1ns/1ns
`default_nettype none

module fmlbrg_top (
  input  logic                               sys_clk,
  input  logic                               sys_rst,
  input  logic [fmlbrg_pkg::FML_DEPTH-1:1]   wb_adr_i,
  input  logic [15:0]                        wb_dat_i,
  input  logic [1:0]                         wb_sel_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_tga_i,
  input  logic                               wb_we_i,
  output logic [15:0]                        wb_dat_o,
  output logic                               wb_ack_o
);
  import fmlbrg_pkg::*;

  logic [INDEX_W-1:0]    tagmem_a;
  logic                  tagmem_we;
  logic [TAGMEM_W-1:0]   tagmem_di, tagmem_do;
  logic                  tag_init_done;   // high once the valid bits are swept clear.
  logic [DATAMEM_AW-1:0] datamem_a;
  logic [1:0]            datamem_we;
  logic [15:0]           datamem_di, datamem_do;
  logic [FML_DEPTH-1:0]  fml_adr;
  logic                  fml_stb, fml_we, fml_ack;
  logic [1:0]            fml_sel;
  logic [15:0]           fml_do, fml_di;  // do flows to memory, di flows back.

  fmlbrg u_ctrl (
    .sys_clk(sys_clk), .sys_rst(sys_rst),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_tga_i(wb_tga_i), .wb_we_i(wb_we_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .tagmem_a_o(tagmem_a), .tagmem_we_o(tagmem_we), .tagmem_di_o(tagmem_di),
    .tagmem_do_i(tagmem_do), .tag_init_done_i(tag_init_done),
    .datamem_a_o(datamem_a), .datamem_we_o(datamem_we), .datamem_di_o(datamem_di),
    .datamem_do_i(datamem_do),
    .fml_adr_o(fml_adr), .fml_stb_o(fml_stb), .fml_we_o(fml_we), .fml_sel_o(fml_sel),
    .fml_do_o(fml_do), .fml_ack_i(fml_ack), .fml_di_i(fml_di)
  );

  fmlbrg_tagmem u_tagmem (
    .sys_clk(sys_clk), .sys_rst(sys_rst),
    .tagmem_a_i(tagmem_a), .tagmem_we_i(tagmem_we), .tagmem_di_i(tagmem_di),
    .tagmem_do_o(tagmem_do), .init_done_o(tag_init_done)
  );

  fmlbrg_datamem u_datamem (
    .sys_clk(sys_clk),
    .datamem_a_i(datamem_a), .datamem_we_i(datamem_we), .datamem_di_i(datamem_di),
    .datamem_do_o(datamem_do)
  );

  fml_burst_mem u_mem (                   // stands in for the SDRAM controller.
    .sys_clk(sys_clk), .sys_rst(sys_rst),
    .fml_adr_i(fml_adr), .fml_stb_i(fml_stb), .fml_we_i(fml_we), .fml_sel_i(fml_sel),
    .fml_do_i(fml_do), .fml_ack_o(fml_ack), .fml_di_o(fml_di)
  );

endmodule

`default_nettype wire

//--- tb_fmlbrg_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fmlbrg_top;
  import fmlbrg_pkg::*;

  localparam int K_READ = 0;                       // plain Wishbone read.
  localparam int K_WRITE = 1;                      // Wishbone write with byte selects.
  localparam int K_INVAL = 2;                      // read cycle with tga set.
  localparam int N_DIRECTED = 17;                  // hand-written rows at the head of the table.
  localparam int NUM_ROWS = N_DIRECTED + 24;       // random rows fill the tail.
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 80 + 100;
  localparam int MEM_WORDS = 1 << (FML_DEPTH - 1); // words behind the bridge.

  logic        sys_clk;
  logic        sys_rst;
  logic [FML_DEPTH-1:1] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [1:0]  wb_sel_i;
  logic        wb_cyc_i, wb_stb_i, wb_tga_i, wb_we_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;

  int                   kind_t [0:NUM_ROWS-1];     // operation of each row.
  logic [FML_DEPTH-2:0] adr_t [0:NUM_ROWS-1];      // word address of each row.
  logic [15:0]          dat_t [0:NUM_ROWS-1];
  logic [1:0]           sel_t [0:NUM_ROWS-1];
  logic                 chk_t [0:NUM_ROWS-1];      // row must ack at its fixed hit cycle.
  logic [15:0]          shadow [0:MEM_WORDS-1];    // expected content of the whole memory.
  int                   n_rows;
  int                   err_cnt;
  int unsigned          cycle_cnt;

  fmlbrg_top fmlbrg_top_inst (
    .sys_clk(sys_clk), .sys_rst(sys_rst),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_tga_i(wb_tga_i), .wb_we_i(wb_we_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o)
  );

  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;                // 40 ns period.
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles, a request never got its ack", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns %s, expected %0h, got %0h", $time, msg, expected, actual);
      err_cnt++;                                   // the row is marked failed by its caller.
    end
  endtask

  task automatic add_row(input int kind, input logic [FML_DEPTH-2:0] adr,
                         input logic [15:0] dat, input logic [1:0] sel, input logic chk);
    kind_t[n_rows] = kind;
    adr_t[n_rows] = adr;
    dat_t[n_rows] = dat;
    sel_t[n_rows] = sel;
    chk_t[n_rows] = chk;
    n_rows++;
  endtask

  // one Wishbone cycle, entered and left 2 ns after a rising edge.
  task automatic run_request(input int kind, input logic [FML_DEPTH-2:0] adr,
                             input logic [15:0] dat, input logic [1:0] sel,
                             output int cycles, output logic [15:0] rdata);
    repeat (BURST_LEN) begin
      @(posedge sys_clk);                          // lets a refill tail finish first.
      #2;
    end
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_we_i = (kind == K_WRITE);
    wb_tga_i = (kind == K_INVAL);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    cycles = 0;
    do begin
      @(posedge sys_clk);
      #2;
      cycles++;                                    // edges since the request went out.
    end while (!wb_ack_o);
    rdata = wb_dat_o;                              // read data is valid with the ack.
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_tga_i = 1'b0;
  endtask

  initial begin
    logic [FML_DEPTH-2:0] line_base [0:4];
    logic [FML_DEPTH-2:0] adr;
    logic [15:0]          rdata;
    logic [15:0]          exp_word;
    int                   cycles, r, kind, seed_ret, errs_before, pass_cnt, fail_cnt;
    cycle_cnt = 0;
    err_cnt = 0;
    n_rows = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    sys_rst = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_tga_i = 1'b0;
    wb_we_i = 1'b0;
    seed_ret = $urandom(32'h403e);                 // the only seeding of the run.
    for (int w = 0; w < MEM_WORDS; w++) shadow[w] = w[15:0] ^ FML_INIT_XOR;

    add_row(K_READ,  11'h02A, 16'h0000, 2'b11, 1'b0); // cold line, clean miss.
    add_row(K_READ,  11'h02A, 16'h0000, 2'b11, 1'b1); // same word now hits.
    add_row(K_READ,  11'h02D, 16'h0000, 2'b11, 1'b1); // other word of that line.
    add_row(K_WRITE, 11'h02A, 16'h1234, 2'b01, 1'b1); // low byte only.
    add_row(K_READ,  11'h02A, 16'h0000, 2'b11, 1'b1);
    add_row(K_WRITE, 11'h02A, 16'hBEEF, 2'b11, 1'b1); // both bytes.
    add_row(K_READ,  11'h02A, 16'h0000, 2'b11, 1'b1);
    add_row(K_WRITE, 11'h063, 16'h5A5A, 2'b11, 1'b0); // write miss on index 12.
    add_row(K_READ,  11'h163, 16'h0000, 2'b11, 1'b0); // other tag evicts the dirty line.
    add_row(K_READ,  11'h063, 16'h0000, 2'b11, 1'b0); // comes back from memory.
    add_row(K_WRITE, 11'h090, 16'hC0DE, 2'b10, 1'b0); // high byte, cold line.
    add_row(K_READ,  11'h090, 16'h0000, 2'b11, 1'b1);
    add_row(K_INVAL, 11'h090, 16'h0000, 2'b11, 1'b0); // dirty, so written back first.
    add_row(K_READ,  11'h090, 16'h0000, 2'b11, 1'b0); // fresh refill.
    add_row(K_INVAL, 11'h090, 16'h0000, 2'b11, 1'b1); // clean invalidate.
    add_row(K_READ,  11'h12D, 16'h0000, 2'b11, 1'b0); // pushes out the dirty index 5 line.
    add_row(K_READ,  11'h02A, 16'h0000, 2'b11, 1'b0);

    line_base[0] = 11'h028;                        // three lines that share index 5.
    line_base[1] = 11'h128;
    line_base[2] = 11'h228;
    line_base[3] = 11'h360;                        // index 12.
    line_base[4] = 11'h4F0;                        // index 30.
    while (n_rows < NUM_ROWS) begin
      r = $urandom % 10;
      kind = (r < 5) ? K_READ : ((r < 8) ? K_WRITE : K_INVAL);
      adr = line_base[$urandom % 5] | 11'($urandom % 8);
      add_row(kind, adr, 16'($urandom), 2'(($urandom % 3) + 1), 1'b0);
    end

    repeat (2) @(posedge sys_clk);                 // reset held for two cycles.
    #2;
    sys_rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      errs_before = err_cnt;
      run_request(kind_t[i], adr_t[i], dat_t[i], sel_t[i], cycles, rdata);
      if (kind_t[i] == K_WRITE) begin
        if (sel_t[i][0]) shadow[adr_t[i]][7:0] = dat_t[i][7:0];
        if (sel_t[i][1]) shadow[adr_t[i]][15:8] = dat_t[i][15:8];
      end
      exp_word = shadow[adr_t[i]];                 // invalidates keep the data as it is.
      if (kind_t[i] == K_READ) check(rdata, exp_word, $sformatf("row %0d read data", i));
      if (chk_t[i]) check(cycles, (kind_t[i] == K_READ) ? 2 : 3,
                          $sformatf("row %0d ack cycle", i));
      if (err_cnt == errs_before) pass_cnt++;
      else fail_cnt++;
      $display("row %0d kind %0d adr %h sel %b ack after %0d cycles, %s", i, kind_t[i],
               adr_t[i], sel_t[i], cycles, (err_cnt == errs_before) ? "ok" : "wrong");
    end

    $display("summary %0d rows passed, %0d rows failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
fmlbrg_pkg.sv
fmlbrg_tagmem.sv
fmlbrg_datamem.sv
fmlbrg.sv
fml_burst_mem.sv
fmlbrg_top.sv
tb_fmlbrg_top.sv
